// ==== hw/lac_ring_pkg.sv ====
// ring parameters, coefficient parameters and the vector types built from them
`default_nettype none

package lac_ring_pkg;

  // ----------------------------------------------------------------------
  // ring and scheme parameters
  // ----------------------------------------------------------------------
  localparam int Q        = 251;
  localparam int N        = 32;
  localparam int H        = 8;
  localparam int CORE_NUM = 4;
  localparam int COEFF_W  = 8;

  // 2^8 = 256 = Q + 5
  localparam int FOLD_K = (1 << COEFF_W) % Q;

  localparam int IDX_W      = $clog2(N);
  localparam int POS_ADDR_W = $clog2(H / CORE_NUM);

  // ----------------------------------------------------------------------
  // vector types
  // ----------------------------------------------------------------------
  typedef logic [COEFF_W-1:0] coeff_t;
  typedef logic [IDX_W-1:0]   idx_t;

  // slot j holds the position handled by core j
  typedef idx_t [CORE_NUM-1:0] pos_word_t;

  typedef logic [POS_ADDR_W-1:0] pos_addr_t;

  // four terms below 256 fit in two extra bits
  typedef logic [COEFF_W+1:0] sum_t;

endpackage

`default_nettype wire

// ==== hw/lac_sched_pkg.sv ====
// controller state enum, pass constants and pipeline latencies
`default_nettype none

package lac_sched_pkg;

  // one pass per position word
  localparam int PASSES = lac_ring_pkg::H / lac_ring_pkg::CORE_NUM;

  // passes from here on carry the -1 positions
  localparam int NEG_PASS = (lac_ring_pkg::H / 2) / lac_ring_pkg::CORE_NUM;

  // sum, fold and subtract stages of the adder
  localparam int ADD_LAT = 3;

  // read then add ahead of the result write
  localparam int ACC_LAT = 2;

  typedef enum logic [2:0] {
    IDLE,
    FETCH,
    RUN,
    NEXT,
    FINISH
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/sparse_mul_ctrl.sv ====
// pass sequencer: busy/done handshake, position fetch, sign and first-pass flags
`default_nettype none

module sparse_mul_ctrl (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      start,
  input  wire                      pass_done,
  output logic                     busy,
  output logic                     done,
  output logic                     pos_rd_en,
  output lac_ring_pkg::pos_addr_t  pos_rd_addr,
  output logic                     pass_start,
  output logic                     pass_neg,
  output logic                     first_pass
);

  lac_sched_pkg::ctrl_state_t state;
  lac_ring_pkg::pos_addr_t    pass_cnt;

  logic last_pass;

  assign last_pass = (pass_cnt == lac_ring_pkg::pos_addr_t'(lac_sched_pkg::PASSES - 1));

  // ----------------------------------------------------------------------
  // state machine
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state    <= lac_sched_pkg::IDLE;
      pass_cnt <= '0;
    end
    else
    begin
      case (state)
        lac_sched_pkg::IDLE,
        lac_sched_pkg::FINISH:
        begin
          // a new run may follow the done cycle directly
          if (start)
          begin
            state    <= lac_sched_pkg::FETCH;
            pass_cnt <= '0;
          end
          else
          begin
            state <= lac_sched_pkg::IDLE;
          end
        end
        lac_sched_pkg::FETCH:
        begin
          state <= lac_sched_pkg::RUN;
        end
        lac_sched_pkg::RUN:
        begin
          // wait for the last index of this pass to land in the result RAM
          if (pass_done)
          begin
            state <= last_pass ? lac_sched_pkg::FINISH : lac_sched_pkg::NEXT;
          end
        end
        lac_sched_pkg::NEXT:
        begin
          pass_cnt <= pass_cnt + 1'b1;
          state    <= lac_sched_pkg::FETCH;
        end
        default:
        begin
          state <= lac_sched_pkg::IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // outputs decoded from the state register
  // ----------------------------------------------------------------------
  assign busy = (state == lac_sched_pkg::FETCH) || (state == lac_sched_pkg::RUN) ||
                (state == lac_sched_pkg::NEXT);
  assign done = (state == lac_sched_pkg::FINISH);

  // position word for this pass is read while the pass is kicked off
  assign pos_rd_en   = (state == lac_sched_pkg::FETCH);
  assign pos_rd_addr = pass_cnt;
  assign pass_start  = (state == lac_sched_pkg::FETCH);

  assign pass_neg   = (pass_cnt >= lac_sched_pkg::NEG_PASS);
  assign first_pass = (pass_cnt == '0);

endmodule

`default_nettype wire

// ==== hw/term_gather.sv ====
// coefficient and position RAMs, rotating read addresses, negacyclic sign correction
`default_nettype none

module term_gather (
  input  wire                                               clk,
  input  wire                                               rst_n,
  input  wire                                               poly_wr_en,
  input  wire lac_ring_pkg::idx_t                           poly_wr_addr,
  input  wire lac_ring_pkg::coeff_t                         poly_wr_data,
  input  wire                                               pos_wr_en,
  input  wire lac_ring_pkg::pos_addr_t                      pos_wr_addr,
  input  wire lac_ring_pkg::pos_word_t                      pos_wr_data,
  input  wire                                               pos_rd_en,
  input  wire lac_ring_pkg::pos_addr_t                      pos_rd_addr,
  input  wire                                               pass_start,
  input  wire                                               pass_neg,
  input  wire                                               first_pass,
  output logic                                              term_valid,
  output lac_ring_pkg::idx_t                                term_idx,
  output logic                                              term_first,
  output lac_ring_pkg::coeff_t [lac_ring_pkg::CORE_NUM-1:0] terms
);

  lac_ring_pkg::coeff_t    poly_mem [lac_ring_pkg::N];
  lac_ring_pkg::pos_word_t pos_mem [lac_sched_pkg::PASSES];

  lac_ring_pkg::pos_word_t pos_q;
  logic                    load_pend;
  logic                    neg_r;
  logic                    first_r;

  lac_ring_pkg::idx_t   [lac_ring_pkg::CORE_NUM-1:0] rd_addr;
  lac_ring_pkg::coeff_t [lac_ring_pkg::CORE_NUM-1:0] a_q;
  lac_ring_pkg::idx_t                                k_cnt;
  logic                                              running;

  // sideband of the coefficient read stage
  logic               rd_valid;
  lac_ring_pkg::idx_t rd_k;
  logic               rd_first;

  // ----------------------------------------------------------------------
  // RAMs
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (poly_wr_en)
      poly_mem[poly_wr_addr] <= poly_wr_data;
    if (pos_wr_en)
      pos_mem[pos_wr_addr] <= pos_wr_data;
    // holds the last word for the whole pass
    if (pos_rd_en)
      pos_q <= pos_mem[pos_rd_addr];
  end

  // ----------------------------------------------------------------------
  // pass sequencing and address rotation
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      load_pend <= 1'b0;
      running   <= 1'b0;
      k_cnt     <= '0;
      rd_valid  <= 1'b0;
    end
    else
    begin
      load_pend <= pass_start;
      rd_valid  <= running;
      if (load_pend)
      begin
        running <= 1'b1;
        k_cnt   <= '0;
      end
      else if (running)
      begin
        k_cnt <= k_cnt + 1'b1;
        if (k_cnt == lac_ring_pkg::idx_t'(lac_ring_pkg::N - 1))
          running <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (pass_start)
    begin
      neg_r   <= pass_neg;
      first_r <= first_pass;
    end
    rd_k     <= k_cnt;
    rd_first <= first_r;
  end

  // core j reads a[(k - p_j) mod N], starting at N - p_j
  for (genvar j = 0; j < lac_ring_pkg::CORE_NUM; j++)
  begin : g_core
    logic keep;

    always_ff @(posedge clk)
    begin
      if (load_pend)
        rd_addr[j] <= lac_ring_pkg::idx_t'(lac_ring_pkg::N - pos_q[j]);
      else if (running)
        rd_addr[j] <= rd_addr[j] + 1'b1;
      a_q[j] <= poly_mem[rd_addr[j]];
    end

    // wrapped terms (k < p) pick up the x^N = -1 sign
    assign keep = neg_r ? (rd_k < pos_q[j]) : (rd_k >= pos_q[j]);

    always_ff @(posedge clk)
    begin
      terms[j] <= keep ? a_q[j] : lac_ring_pkg::coeff_t'(lac_ring_pkg::Q - a_q[j]);
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      term_valid <= 1'b0;
    else
      term_valid <= rd_valid;
    term_idx   <= rd_k;
    term_first <= rd_first;
  end

endmodule

`default_nettype wire

// ==== hw/mod_q_adder.sv ====
// three-stage sum of CORE_NUM terms with modulo-Q reduction
`default_nettype none

module mod_q_adder (
  input  wire                                              clk,
  input  wire                                              rst_n,
  input  wire                                              in_valid,
  input  wire lac_ring_pkg::idx_t                          in_idx,
  input  wire                                              in_first,
  input  wire lac_ring_pkg::coeff_t [lac_ring_pkg::CORE_NUM-1:0] terms,
  output logic                                             sum_valid,
  output lac_ring_pkg::idx_t                               sum_idx,
  output logic                                             sum_first,
  output lac_ring_pkg::coeff_t                             sum
);

  lac_ring_pkg::sum_t               raw_sum;
  lac_ring_pkg::sum_t               s1_sum;
  logic [lac_ring_pkg::COEFF_W:0]   fold;
  logic [lac_ring_pkg::COEFF_W:0]   s2_fold;

  logic               [lac_sched_pkg::ADD_LAT-1:0] v_pipe;
  logic               [lac_sched_pkg::ADD_LAT-1:0] first_pipe;
  lac_ring_pkg::idx_t [lac_sched_pkg::ADD_LAT-1:0] idx_pipe;

  always_comb
  begin
    raw_sum = '0;
    for (int j = 0; j < lac_ring_pkg::CORE_NUM; j++)
      raw_sum = raw_sum + lac_ring_pkg::sum_t'(terms[j]);
  end

  // top bits count multiples of 256, each worth FOLD_K mod Q
  assign fold = (lac_ring_pkg::COEFF_W+1)'(s1_sum[lac_ring_pkg::COEFF_W-1:0]) +
                (lac_ring_pkg::COEFF_W+1)'(s1_sum[lac_ring_pkg::COEFF_W+1:lac_ring_pkg::COEFF_W] *
                                           lac_ring_pkg::FOLD_K);

  // ----------------------------------------------------------------------
  // data stages
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    s1_sum  <= raw_sum;
    s2_fold <= fold;
    // folded value stays below 2Q, one subtract is enough
    sum <= (s2_fold >= lac_ring_pkg::Q) ? lac_ring_pkg::coeff_t'(s2_fold - lac_ring_pkg::Q)
                                        : lac_ring_pkg::coeff_t'(s2_fold);
  end

  // index and flags ride alongside
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      v_pipe <= '0;
    else
      v_pipe <= {v_pipe[lac_sched_pkg::ADD_LAT-2:0], in_valid};
    first_pipe <= {first_pipe[lac_sched_pkg::ADD_LAT-2:0], in_first};
    idx_pipe   <= {idx_pipe[lac_sched_pkg::ADD_LAT-2:0], in_idx};
  end

  assign sum_valid = v_pipe[lac_sched_pkg::ADD_LAT-1];
  assign sum_first = first_pipe[lac_sched_pkg::ADD_LAT-1];
  assign sum_idx   = idx_pipe[lac_sched_pkg::ADD_LAT-1];

endmodule

`default_nettype wire

// ==== hw/res_accum.sv ====
// result RAM with read-modify-write accumulation and the registered readout port
`default_nettype none

module res_accum (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        sum_valid,
  input  wire lac_ring_pkg::idx_t    sum_idx,
  input  wire                        sum_first,
  input  wire lac_ring_pkg::coeff_t  sum,
  input  wire                        res_rd_en,
  input  wire lac_ring_pkg::idx_t    res_rd_addr,
  output lac_ring_pkg::coeff_t       res_rd_data,
  output logic                       pass_done
);

  lac_ring_pkg::coeff_t res_mem [lac_ring_pkg::N];

  lac_ring_pkg::idx_t   rd_addr;
  lac_ring_pkg::coeff_t rd_q;
  logic                 ext_pend;

  // stage one holds the incoming item while the old value is read
  lac_ring_pkg::coeff_t s1_sum;
  logic                 s1_first;

  // stage two holds the unreduced accumulation
  logic [lac_ring_pkg::COEFF_W:0] s2_acc;
  lac_ring_pkg::coeff_t           old_val;
  lac_ring_pkg::coeff_t           wr_data;

  logic               [lac_sched_pkg::ACC_LAT-1:0] v_pipe;
  lac_ring_pkg::idx_t [lac_sched_pkg::ACC_LAT-1:0] idx_pipe;

  logic               wr_en;
  lac_ring_pkg::idx_t wr_addr;

  // the external port only reads while the controller is idle
  assign rd_addr = res_rd_en ? res_rd_addr : sum_idx;

  assign wr_en   = v_pipe[lac_sched_pkg::ACC_LAT-1];
  assign wr_addr = idx_pipe[lac_sched_pkg::ACC_LAT-1];

  // pass 0 starts from zero whatever the RAM still holds
  assign old_val = s1_first ? '0 : rd_q;

  assign wr_data = (s2_acc >= lac_ring_pkg::Q) ? lac_ring_pkg::coeff_t'(s2_acc - lac_ring_pkg::Q)
                                               : lac_ring_pkg::coeff_t'(s2_acc);

  // ----------------------------------------------------------------------
  // RAM and datapath
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    rd_q <= res_mem[rd_addr];
    if (wr_en)
      res_mem[wr_addr] <= wr_data;
    s1_sum   <= sum;
    s1_first <= sum_first;
    s2_acc   <= (lac_ring_pkg::COEFF_W+1)'(old_val) + (lac_ring_pkg::COEFF_W+1)'(s1_sum);
    if (ext_pend)
      res_rd_data <= rd_q;
  end

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      v_pipe    <= '0;
      ext_pend  <= 1'b0;
      pass_done <= 1'b0;
    end
    else
    begin
      v_pipe    <= {v_pipe[lac_sched_pkg::ACC_LAT-2:0], sum_valid};
      ext_pend  <= res_rd_en;
      // the last index of a pass is being written right now
      pass_done <= wr_en && (wr_addr == lac_ring_pkg::idx_t'(lac_ring_pkg::N - 1));
    end
    idx_pipe <= {idx_pipe[lac_sched_pkg::ACC_LAT-2:0], sum_idx};
  end

endmodule

`default_nettype wire

// ==== hw/sparse_mul.sv ====
// sparse polynomial multiplier top level: controller, gather, adder and accumulator
`default_nettype none

module sparse_mul (
  input  wire                           clk,
  input  wire                           rst_n,
  input  wire                           start,
  output logic                          busy,
  output logic                          done,
  input  wire                           poly_wr_en,
  input  wire lac_ring_pkg::idx_t       poly_wr_addr,
  input  wire lac_ring_pkg::coeff_t     poly_wr_data,
  input  wire                           pos_wr_en,
  input  wire lac_ring_pkg::pos_addr_t  pos_wr_addr,
  input  wire lac_ring_pkg::pos_word_t  pos_wr_data,
  input  wire                           res_rd_en,
  input  wire lac_ring_pkg::idx_t       res_rd_addr,
  output lac_ring_pkg::coeff_t          res_rd_data
);

  // controller to gather
  wire                          pos_rd_en;
  wire lac_ring_pkg::pos_addr_t pos_rd_addr;
  wire                          pass_start;
  wire                          pass_neg;
  wire                          first_pass;

  // gather to adder
  wire                                              term_valid;
  wire lac_ring_pkg::idx_t                          term_idx;
  wire                                              term_first;
  wire lac_ring_pkg::coeff_t [lac_ring_pkg::CORE_NUM-1:0] terms;

  // adder to accumulator, and back to the controller
  wire                       sum_valid;
  wire lac_ring_pkg::idx_t   sum_idx;
  wire                       sum_first;
  wire lac_ring_pkg::coeff_t sum;
  wire                       pass_done;

  sparse_mul_ctrl ctrl0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .pass_done   (pass_done),
    .busy        (busy),
    .done        (done),
    .pos_rd_en   (pos_rd_en),
    .pos_rd_addr (pos_rd_addr),
    .pass_start  (pass_start),
    .pass_neg    (pass_neg),
    .first_pass  (first_pass)
  );

  term_gather gather0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .poly_wr_en   (poly_wr_en),
    .poly_wr_addr (poly_wr_addr),
    .poly_wr_data (poly_wr_data),
    .pos_wr_en    (pos_wr_en),
    .pos_wr_addr  (pos_wr_addr),
    .pos_wr_data  (pos_wr_data),
    .pos_rd_en    (pos_rd_en),
    .pos_rd_addr  (pos_rd_addr),
    .pass_start   (pass_start),
    .pass_neg     (pass_neg),
    .first_pass   (first_pass),
    .term_valid   (term_valid),
    .term_idx     (term_idx),
    .term_first   (term_first),
    .terms        (terms)
  );

  mod_q_adder adder0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (term_valid),
    .in_idx    (term_idx),
    .in_first  (term_first),
    .terms     (terms),
    .sum_valid (sum_valid),
    .sum_idx   (sum_idx),
    .sum_first (sum_first),
    .sum       (sum)
  );

  res_accum accum0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .sum_valid   (sum_valid),
    .sum_idx     (sum_idx),
    .sum_first   (sum_first),
    .sum         (sum),
    .res_rd_en   (res_rd_en),
    .res_rd_addr (res_rd_addr),
    .res_rd_data (res_rd_data),
    .pass_done   (pass_done)
  );

endmodule

`default_nettype wire

// ==== dv/sparse_mul_chk.sv ====
// concurrent assertions on the start/busy/done handshake and the pass control
`default_nettype none

module sparse_mul_chk (
  input wire                             clk,
  input wire                             rst_n,
  input wire                             start,
  input wire                             busy,
  input wire                             done,
  input wire                             pass_start,
  input wire                             pass_done,
  input wire lac_sched_pkg::ctrl_state_t state,
  input wire lac_ring_pkg::pos_addr_t    pass_cnt
);

  // number of assertion failures so far
  int fail_cnt = 0;

  // ----------------------------------------------------------------------
  // handshake
  // ----------------------------------------------------------------------
  a_done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done)
  else
  begin
    $error("done stayed high for more than one cycle");
    fail_cnt++;
  end

  a_busy_rise: assert property (@(posedge clk) disable iff (!rst_n)
    (start && !busy) |=> busy)
  else
  begin
    $error("busy did not rise after an accepted start");
    fail_cnt++;
  end

  // busy may only drop in the done cycle
  a_busy_hold: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(busy) |-> done)
  else
  begin
    $error("busy fell without done");
    fail_cnt++;
  end

  // ----------------------------------------------------------------------
  // pass control
  // ----------------------------------------------------------------------
  // NEXT moves on to FETCH by itself, so it is left out here
  a_start_ignored: assert property (@(posedge clk) disable iff (!rst_n)
    (start && busy && state != lac_sched_pkg::NEXT) |=>
      (state != lac_sched_pkg::FETCH) && (pass_cnt == $past(pass_cnt)))
  else
  begin
    $error("start during busy disturbed the controller");
    fail_cnt++;
  end

  // a pass begins in FETCH, right after an accepted start
  // or two cycles after the previous pass was written
  a_pass_start_fetch: assert property (@(posedge clk) disable iff (!rst_n)
    pass_start |-> (state == lac_sched_pkg::FETCH) &&
                   ($past(start && !busy) || $past(pass_done, 2)))
  else
  begin
    $error("pass_start outside a FETCH that follows a start or a finished pass");
    fail_cnt++;
  end

endmodule

bind sparse_mul_ctrl sparse_mul_chk chk0 (
  .clk        (clk),
  .rst_n      (rst_n),
  .start      (start),
  .busy       (busy),
  .done       (done),
  .pass_start (pass_start),
  .pass_done  (pass_done),
  .state      (state),
  .pass_cnt   (pass_cnt)
);

`default_nettype wire

// ==== dv/sparse_mul_mon.sv ====
// monitor: compares readout words, checks the handshake, reports each test and keeps the counts
`default_nettype none

module sparse_mul_mon (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        start,
  input  wire                        busy,
  input  wire                        done,
  input  wire                        res_rd_en,
  input  wire lac_ring_pkg::idx_t    res_rd_addr,
  input  wire lac_ring_pkg::coeff_t  res_rd_data,
  input  wire lac_ring_pkg::coeff_t  exp_data,
  input  wire [7:0]                  test_id,
  input  wire [7:0]                  exp_dones,
  input  wire                        test_end,
  output int                         tests_run,
  output int                         tests_bad,
  output int                         err_total
);

  // read requests delayed until their word shows on res_rd_data
  logic                 [1:0] req_v;
  lac_ring_pkg::idx_t   [1:0] req_addr;
  lac_ring_pkg::coeff_t [1:0] req_exp;

  logic seen_start = 1'b0;
  int   checks     = 0;
  int   errs       = 0;
  int   done_cnt   = 0;
  int   run_cnt    = 0;
  int   bad_cnt    = 0;
  int   err_sum    = 0;

  assign tests_run = run_cnt;
  assign tests_bad = bad_cnt;
  assign err_total = err_sum;

  always @(posedge clk)
  begin
    if (!rst_n)
    begin
      req_v      <= '0;
      seen_start = 1'b0;
    end
    else
    begin
      // ------------------------------------------------------------------
      // readout data
      // ------------------------------------------------------------------
      if (req_v[1])
      begin
        checks++;
        if (res_rd_data !== req_exp[1])
        begin
          errs++;
          $display("error at %0t: res_rd_data[%0d] got 0x%02h expected 0x%02h",
                   $time, req_addr[1], res_rd_data, req_exp[1]);
        end
      end
      if (res_rd_en && busy)
      begin
        errs++;
        $display("at %0t a result read was requested while busy was high", $time);
      end
      req_v    <= {req_v[0], res_rd_en};
      req_addr <= {req_addr[0], res_rd_addr};
      req_exp  <= {req_exp[0], exp_data};

      // ------------------------------------------------------------------
      // handshake
      // ------------------------------------------------------------------
      // nothing may happen before the first start
      if (!seen_start)
      begin
        checks++;
        if (busy || done)
        begin
          errs++;
          $display("at %0t busy or done was high before any start", $time);
        end
      end
      if (start)
        seen_start = 1'b1;
      if (done)
        done_cnt++;

      if (test_end)
      begin
        checks++;
        if (done_cnt != int'(exp_dones))
        begin
          errs++;
          $display("test %0d saw %0d done pulses where %0d were expected",
                   test_id, done_cnt, exp_dones);
        end
        $display("test %0d: %0d checks, %0d errors, %0d done pulses, %s",
                 test_id, checks, errs, done_cnt, (errs == 0) ? "ok" : "FAILED");
        run_cnt++;
        if (errs != 0)
          bad_cnt++;
        err_sum  = err_sum + errs;
        checks   = 0;
        errs     = 0;
        done_cnt = 0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== dv/sparse_mul_tb.sv ====
// testbench top: clock, reset, golden file reading, stimulus, watchdog and verdict
`default_nettype none

module sparse_mul_tb;

  localparam int N        = lac_ring_pkg::N;
  localparam int H        = lac_ring_pkg::H;
  localparam int CORE_NUM = lac_ring_pkg::CORE_NUM;
  localparam int PASSES   = lac_sched_pkg::PASSES;

  localparam int CLK_HALF = 20;

  // golden file: per case N dense coefficients, H positions, N products
  localparam int CASE_LEN   = 2 * N + H;
  localparam int CASES      = 3;
  localparam int GOLD_WORDS = CASES * CASE_LEN;

  // four multiplications: cases 1, 2, 3 and case 1 again with a stray start
  localparam int RUNS       = 4;
  localparam int RUN_CYCLES = 2 * N + PASSES * (N + 16) + 2 * N;
  localparam int WATCHDOG_T = 2 * RUNS * RUN_CYCLES * 2 * CLK_HALF;
  localparam int DONE_LIMIT = 2 * PASSES * (N + 16);
  localparam int MID_RUN    = N / 2 + 4;

  logic                     clk;
  logic                     rst_n;
  logic                     start;
  logic                     busy;
  logic                     done;
  logic                     poly_wr_en;
  lac_ring_pkg::idx_t       poly_wr_addr;
  lac_ring_pkg::coeff_t     poly_wr_data;
  logic                     pos_wr_en;
  lac_ring_pkg::pos_addr_t  pos_wr_addr;
  lac_ring_pkg::pos_word_t  pos_wr_data;
  logic                     res_rd_en;
  lac_ring_pkg::idx_t       res_rd_addr;
  lac_ring_pkg::coeff_t     res_rd_data;

  lac_ring_pkg::coeff_t exp_data;
  logic [7:0]           test_id;
  logic [7:0]           exp_dones;
  logic                 test_end;
  int                   tests_run;
  int                   tests_bad;
  int                   err_total;
  int                   tb_errors;

  lac_ring_pkg::coeff_t gold [0:GOLD_WORDS-1];

  sparse_mul dut0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .busy         (busy),
    .done         (done),
    .poly_wr_en   (poly_wr_en),
    .poly_wr_addr (poly_wr_addr),
    .poly_wr_data (poly_wr_data),
    .pos_wr_en    (pos_wr_en),
    .pos_wr_addr  (pos_wr_addr),
    .pos_wr_data  (pos_wr_data),
    .res_rd_en    (res_rd_en),
    .res_rd_addr  (res_rd_addr),
    .res_rd_data  (res_rd_data)
  );

  sparse_mul_mon mon0 (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .busy        (busy),
    .done        (done),
    .res_rd_en   (res_rd_en),
    .res_rd_addr (res_rd_addr),
    .res_rd_data (res_rd_data),
    .exp_data    (exp_data),
    .test_id     (test_id),
    .exp_dones   (exp_dones),
    .test_end    (test_end),
    .tests_run   (tests_run),
    .tests_bad   (tests_bad),
    .err_total   (err_total)
  );

  initial
  begin
    clk = 1'b0;
    forever #CLK_HALF clk = ~clk;
  end

  initial
  begin : watchdog
    #(WATCHDOG_T);
    $display("watchdog expired at %0t before the tests completed", $time);
    $display("Regression failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // stimulus tasks, all driving on the falling edge
  // ----------------------------------------------------------------------
  task automatic load_poly(input int c);
    int i;
    for (i = 0; i < N; i++)
    begin
      @(negedge clk);
      poly_wr_en   = 1'b1;
      poly_wr_addr = lac_ring_pkg::idx_t'(i);
      poly_wr_data = gold[c * CASE_LEN + i];
    end
    @(negedge clk);
    poly_wr_en = 1'b0;
  endtask

  // slot j of word w holds position w*CORE_NUM + j
  task automatic load_positions(input int c);
    int w;
    int j;
    lac_ring_pkg::pos_word_t word;
    for (w = 0; w < PASSES; w++)
    begin
      for (j = 0; j < CORE_NUM; j++)
        word[j] = lac_ring_pkg::idx_t'(gold[c * CASE_LEN + N + w * CORE_NUM + j]);
      @(negedge clk);
      pos_wr_en   = 1'b1;
      pos_wr_addr = lac_ring_pkg::pos_addr_t'(w);
      pos_wr_data = word;
    end
    @(negedge clk);
    pos_wr_en = 1'b0;
  endtask

  task automatic wait_done();
    int cycles;
    cycles = 0;
    while (done !== 1'b1 && cycles < DONE_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (done !== 1'b1)
    begin
      tb_errors++;
      $display("done did not arrive within %0d cycles at %0t", DONE_LIMIT, $time);
    end
    @(negedge clk);
  endtask

  task automatic run_mult(input bit stray_start);
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    // a second pulse in the middle of the first pass
    if (stray_start)
    begin
      repeat (MID_RUN) @(negedge clk);
      start = 1'b1;
      @(negedge clk);
      start = 1'b0;
    end
    wait_done();
  endtask

  task automatic read_results(input int c);
    int i;
    for (i = 0; i < N; i++)
    begin
      @(negedge clk);
      res_rd_en   = 1'b1;
      res_rd_addr = lac_ring_pkg::idx_t'(i);
      exp_data    = gold[c * CASE_LEN + N + H + i];
    end
    @(negedge clk);
    res_rd_en = 1'b0;
  endtask

  task automatic open_test(input int id, input int dones);
    test_id   = 8'(id);
    exp_dones = 8'(dones);
  endtask

  // lets the last readout words drain into the monitor first
  task automatic close_test();
    repeat (3) @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial
  begin : main
    int total;
    rst_n        = 1'b0;
    start        = 1'b0;
    poly_wr_en   = 1'b0;
    poly_wr_addr = '0;
    poly_wr_data = '0;
    pos_wr_en    = 1'b0;
    pos_wr_addr  = '0;
    pos_wr_data  = '0;
    res_rd_en    = 1'b0;
    res_rd_addr  = '0;
    exp_data     = '0;
    test_id      = '0;
    exp_dones    = '0;
    test_end     = 1'b0;
    tb_errors    = 0;

    $readmemh("dv/sparse_mul_golden.txt", gold);
    if ($isunknown(gold[GOLD_WORDS-1]))
    begin
      tb_errors++;
      $display("the golden file is missing or shorter than %0d words", GOLD_WORDS);
    end

    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // idle after reset
    open_test(1, 0);
    repeat (4) @(negedge clk);
    close_test();

    open_test(2, 1);
    load_poly(0);
    load_positions(0);
    run_mult(1'b0);
    read_results(0);
    close_test();

    open_test(3, 1);
    load_poly(1);
    load_positions(1);
    run_mult(1'b0);
    read_results(1);
    close_test();

    // same a as case 2, old results still in the RAM
    open_test(4, 1);
    load_positions(2);
    run_mult(1'b0);
    read_results(2);
    close_test();

    open_test(5, 1);
    load_poly(0);
    load_positions(0);
    run_mult(1'b1);
    read_results(0);
    close_test();

    repeat (2) @(negedge clk);
    total = err_total + tb_errors + dut0.ctrl0.chk0.fail_cnt;
    $display("summary: %0d tests, %0d failing tests, %0d errors", tests_run, tests_bad, total);
    if (total == 0 && tests_run == 5)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/sparse_mul_golden.txt ====
// per case: 4 lines of a[0..31], 1 line of positions (four +1 then four -1), 4 lines of c[0..31]
// case 1 positions spread, case 2 with 0 and 31, case 3 reuses the a of case 2
01 02 03 04 05 06 07 08
09 0a 0b 0c 0d 0e 0f 10
11 12 13 14 15 16 17 18
19 1a 1b 1c 1d 1e 1f 20
00 05 0d 16 03 09 11 1c
11 13 15 f0 f0 17 19 1b
1d f8 f8 f8 f8 1f 21 23
25 05 05 05 05 05 27 29
2b 2d 2f 31 11 11 11 11
c8 c9 ca cb cc cd ce cf
d0 d1 d2 d3 d4 d5 d6 d7
d8 d9 da db dc dd de df
e0 e1 e2 e3 e4 e5 e6 e7
00 0b 13 1a 04 0e 17 1f
a5 a7 a9 ab f3 f3 f3 f3
f3 f3 f3 ad af b1 f9 f9
f9 f9 f9 b3 b5 b7 b9 06
06 06 bb bd bf c1 c3 10
c8 c9 ca cb cc cd ce cf
d0 d1 d2 d3 d4 d5 d6 d7
d8 d9 da db dc dd de df
e0 e1 e2 e3 e4 e5 e6 e7
1f 02 09 10 00 05 14 1b
4c 4a 02 02 02 48 46 44
42 f5 f5 f5 f5 f5 f5 f5
af b1 b3 b5 02 02 02 02
02 02 02 48 46 44 42 f5

// ==== sim.f ====
hw/lac_ring_pkg.sv
hw/lac_sched_pkg.sv
hw/sparse_mul_ctrl.sv
hw/term_gather.sv
hw/mod_q_adder.sv
hw/res_accum.sv
hw/sparse_mul.sv
dv/sparse_mul_chk.sv
dv/sparse_mul_mon.sv
dv/sparse_mul_tb.sv
